/* bench/execCoreTb.sv */
/*
   Testbench for the single-cycle decode and execute datapath
   Reads instruction records from the stim file and checks every step
*/
`default_nettype none
`timescale 1ns/100ps
module execCoreTb;

   localparam int halfPeriod  = 20;
   localparam int driveDelay  = 2;
   localparam int sampleDelay = 2 * halfPeriod - 2 * driveDelay;
   localparam int resetCycles = 10;
   localparam int waitLimit   = 50;
   localparam int maxRecs     = 64;
   localparam int recWords    = 5;

   logic             clk;
   logic             rstN;
   isaPkg::instrWord instruction;
   logic             instrValid;
   logic [15:0]      result;
   logic [2:0]       wrReg;
   logic             wrEn;
   logic             memWrt;
   logic             immSrc;
   logic             aluJump;
   isaPkg::brTypeT   brType;
   logic             err;

   // Five words per record as listed in the stim file header
   logic [15:0] stimMem [0:maxRecs * recWords - 1];

   integer seed;
   int     testErrs;
   int     passCount;
   int     failCount;
   logic   timedOut;

   execCore u_dut (
      .clk         (clk),
      .rstN        (rstN),
      .instruction (instruction),
      .instrValid  (instrValid),
      .result      (result),
      .wrReg       (wrReg),
      .wrEn        (wrEn),
      .memWrt      (memWrt),
      .immSrc      (immSrc),
      .aluJump     (aluJump),
      .brType      (brType),
      .err         (err)
   );

   ////////////////////////////////////////////////////////////////////////
   // Clock and reset
   ////////////////////////////////////////////////////////////////////////

   initial clk = 1'b0;
   always #halfPeriod clk = ~clk;

   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      #driveDelay;
      rstN = 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////

   // Drive after the edge, return just before the next one
   task automatic driveCycle(input logic [15:0] word, input logic valid);
      @(posedge clk);
      #driveDelay;
      instruction = word;
      instrValid  = valid;
      #sampleDelay;
   endtask

   task automatic reportMismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
      $display("ERR at %0d ns: %s = %h, expected %h", $time, name, got, expected);
      testErrs++;
   endtask

   task automatic closeTest(input int testNum, input int steps);
      if (testErrs == 0) begin
         passCount++;
         $display("Test %0d done: %0d steps, no mismatches", testNum, steps);
      end else begin
         failCount++;
         $display("Test %0d done: %0d steps, %0d mismatches", testNum, steps, testErrs);
      end
      testErrs = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////

   initial begin
      int          rec;
      int          numRecs;
      int          base;
      int          idle;
      int          cnt;
      int          curTest;
      int          testNum;
      int          testRecs;
      int          assertFails;
      logic [15:0] word;
      logic [15:0] expResult;
      logic        expWrEn;
      logic [2:0]  expWrReg;
      logic        expMemWrt;

      instruction = '0;
      instrValid  = 1'b0;
      seed        = 32498;
      testErrs    = 0;
      passCount   = 0;
      failCount   = 0;
      timedOut    = 1'b0;
      curTest     = -1;
      testRecs    = 0;
      numRecs     = 0;
      $readmemh("bench/execCore_stim.txt", stimMem);

      // Wait for reset release with a limit
      cnt = 0;
      while (rstN !== 1'b1 && cnt < resetCycles + waitLimit) begin
         @(posedge clk);
         cnt++;
      end
      if (rstN !== 1'b1) begin
         timedOut = 1'b1;
      end

      // Records stop at the first word the file left unloaded
      while (numRecs < maxRecs && !$isunknown(stimMem[numRecs * recWords])) begin
         numRecs++;
      end

      if (!timedOut) begin
         for (rec = 0; rec < numRecs; rec++) begin
            base      = rec * recWords;
            word      = stimMem[base];
            expResult = stimMem[base + 1];
            expWrEn   = stimMem[base + 2][0];
            expWrReg  = stimMem[base + 3][2:0];
            testNum   = stimMem[base + 4];
            // Only a store drives the memory write
            expMemWrt = (word[15:11] == isaPkg::opSt);

            if (testNum != curTest) begin
               if (curTest >= 0) begin
                  closeTest(curTest, testRecs);
               end
               curTest  = testNum;
               testRecs = 0;
            end

            // Word already on the bus but not yet valid
            idle = 1 + ({$random(seed)} % 3);
            for (cnt = 0; cnt < idle; cnt++) begin
               driveCycle(word, 1'b0);
               if (wrEn !== 1'b0) begin
                  reportMismatch("wrEn", wrEn, 16'h0000);
               end
            end

            driveCycle(word, 1'b1);
            if (wrEn !== expWrEn) begin
               reportMismatch("wrEn", wrEn, expWrEn);
            end
            if (memWrt !== expMemWrt) begin
               reportMismatch("memWrt", memWrt, expMemWrt);
            end
            if (err !== 1'b0) begin
               reportMismatch("err", err, 16'h0000);
            end
            // None of the kept instructions touches the PC controls
            if (immSrc !== 1'b0) begin
               reportMismatch("immSrc", immSrc, 16'h0000);
            end
            if (aluJump !== 1'b0) begin
               reportMismatch("aluJump", aluJump, 16'h0000);
            end
            if (brType !== isaPkg::brNone) begin
               reportMismatch("brType", brType, isaPkg::brNone);
            end
            // Result and destination matter only on a write
            if (expWrEn && result !== expResult) begin
               reportMismatch("result", result, expResult);
            end
            if (expWrEn && wrReg !== expWrReg) begin
               reportMismatch("wrReg", wrReg, expWrReg);
            end
            testRecs++;
         end
         if (curTest >= 0) begin
            closeTest(curTest, testRecs);
         end
      end

      assertFails = u_dut.u_assert.assertFails;
      if (timedOut) begin
         $display("Timeout: reset was not released within %0d cycles", resetCycles + waitLimit);
      end
      if (numRecs == 0) begin
         $display("No stimulus records were read from the stim file");
      end
      if (assertFails != 0) begin
         $display("Bound assertions failed %0d times", assertFails);
      end
      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (!timedOut && numRecs > 0 && failCount == 0 && assertFails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
`default_nettype wire

/* bench/execCore_assert.sv */
/*
   Bound checks on the datapath write, memory and error outputs
*/
`default_nettype none
`timescale 1ns/100ps
module execCoreAssert (
   input wire clk,
   input wire rstN,
   input wire instrValid,
   input wire wrEn,
   input wire memWrt,
   input wire err
);

   // Failures so far
   int assertFails = 0;

   // A register write needs a valid instruction
   writeNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
      wrEn |-> instrValid)
      else begin
         $error("wrEn high while instrValid is low");
         assertFails++;
      end

   // Register file never sees an unknown write
   noRegFileErr: assert property (@(posedge clk) disable iff (!rstN) !err)
      else begin
         $error("register file err raised");
         assertFails++;
      end

   // A store writes memory only
   storeNoWrite: assert property (@(posedge clk) disable iff (!rstN)
      !(memWrt && wrEn))
      else begin
         $error("memWrt and wrEn high together");
         assertFails++;
      end

endmodule

bind execCore execCoreAssert u_assert (
   .clk        (clk),
   .rstN       (rstN),
   .instrValid (instrValid),
   .wrEn       (wrEn),
   .memWrt     (memWrt),
   .err        (err)
);
`default_nettype wire

/* bench/execCore_stim.txt */
// Columns: instruction, expected result, expected wrEn, expected wrReg, test number
// Result and wrReg are not checked on rows with wrEn 0
D804 0000 1 1 1
C180 FF80 1 1 2
C212 0012 1 2 2
9234 1234 1 2 2
91F0 80F0 1 1 2
527F 122B 1 3 2
5A9F 1220 1 4 2
42BF 1233 1 5 2
4ADE EDCA 1 6 2
D95C 9324 1 7 3
DA2D 6EBC 1 3 3
DDD2 FFF9 1 4 3
DF57 8100 1 5 3
C614 0014 1 6 4
D2CC 2341 1 3 4
D1CD 0F00 1 3 4
D1CE 080F 1 3 4
D5CF 0810 1 3 4
A288 3412 1 4 4
A981 01E0 1 4 4
B29F 2468 1 4 4
B98C 0008 1 4 4
CA14 2C48 1 5 4
E24C 0001 1 3 5
E14C 0000 1 3 5
E94C 0001 1 3 5
EA2C 0000 1 3 5
F24C 0001 1 3 5
F4CC 0001 1 3 5
F68C 0000 1 3 5
F9EC 0001 1 3 5
FACC 0000 1 3 5
82E4 0000 0 0 6
D90C 80F0 1 3 6
0808 0000 0 0 6
0008 0000 0 0 6
DA10 1234 1 4 6

/* list.f */
verilog/isaPkg.sv
verilog/regFile.sv
verilog/decode.sv
verilog/execute.sv
verilog/execCore.sv
bench/execCore_assert.sv
bench/execCoreTb.sv

/* verilog/decode.sv */
/*
   Decode stage with control generation and immediate extension
   B operand select, destination select and the register file
*/
`default_nettype none
`timescale 1ns/100ps
module decode (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire isaPkg::instrWord  instruction,
   input  wire                    instrValid,
   input  wire  [15:0]            wrData,
   output logic [15:0]            opA,
   output logic [15:0]            opB,
   output logic [15:0]            rtData,
   output isaPkg::aluOp           oper,
   output logic                   invA,
   output logic                   invB,
   output logic                   cin,
   output isaPkg::regSrcSel       regSrc,
   output logic [2:0]             wrSel,
   output logic                   wrEn,
   output logic                   immSrc,
   output logic                   aluJump,
   output logic                   memWrt,
   output isaPkg::brTypeT         brType,
   output logic                   err
);

   logic [4:0]       opcode;
   logic             regWrt;
   logic             zeroExt;
   isaPkg::bSrcSel   bSrc;
   isaPkg::regDstSel regDst;
   logic [15:0]      ext5;
   logic [15:0]      ext8;
   logic [15:0]      slbiVal;

   // Same position in every view
   assign opcode = instruction.j.opcode;

   // add, sub, xor, andn share this order in funct and in the 010xx opcodes
   function automatic isaPkg::aluOp arithOper(input logic [1:0] sel);
      if (!sel[1]) begin
         return isaPkg::aluAdd;
      end
      return sel[0] ? isaPkg::aluAnd : isaPkg::aluXor;
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // Control decode
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      // Defaults describe an instruction that writes nothing
      oper    = isaPkg::aluAdd;
      invA    = 1'b0;
      invB    = 1'b0;
      bSrc    = isaPkg::bRt;
      regSrc  = isaPkg::srcAlu;
      regDst  = isaPkg::dstRRd;
      regWrt  = 1'b0;
      zeroExt = 1'b0;
      immSrc  = 1'b0;
      aluJump = 1'b0;
      memWrt  = 1'b0;
      brType  = isaPkg::brNone;
      case (opcode)
         isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni: begin
            oper    = arithOper(opcode[1:0]);
            invA    = (opcode == isaPkg::opSubi);
            invB    = (opcode == isaPkg::opAndni);
            // XORI and ANDNI take the immediate unsigned
            zeroExt = opcode[1];
            bSrc    = isaPkg::bExt5;
            regDst  = isaPkg::dstIRd;
            regWrt  = 1'b1;
         end
         isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
            oper   = {1'b0, opcode[1:0]};
            bSrc   = isaPkg::bExt5;
            regDst = isaPkg::dstIRd;
            regWrt = 1'b1;
         end
         isaPkg::opAlu: begin
            oper   = arithOper(instruction.r.funct);
            // SUB is rt minus rs
            invA   = (instruction.r.funct == 2'b01);
            invB   = (instruction.r.funct == 2'b11);
            regWrt = 1'b1;
         end
         isaPkg::opShift: begin
            oper   = {1'b0, instruction.r.funct};
            regWrt = 1'b1;
         end
         isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle: begin
            // rs minus rt, flags read in execute
            invB   = 1'b1;
            regWrt = 1'b1;
         end
         isaPkg::opSco, isaPkg::opBtr: begin
            regWrt = 1'b1;
         end
         isaPkg::opLbi: begin
            bSrc   = isaPkg::bExt8;
            regSrc = isaPkg::srcB;
            regDst = isaPkg::dstRs;
            regWrt = 1'b1;
         end
         isaPkg::opSlbi: begin
            zeroExt = 1'b1;
            bSrc    = isaPkg::bSlbi;
            regSrc  = isaPkg::srcB;
            regDst  = isaPkg::dstRs;
            regWrt  = 1'b1;
         end
         isaPkg::opSt: begin
            bSrc   = isaPkg::bExt5;
            memWrt = 1'b1;
         end
         // Load data and link values come from stages outside this core
         // so these keep their selects but never write
         isaPkg::opLd: begin
            bSrc   = isaPkg::bExt5;
            regSrc = isaPkg::srcMem;
            regDst = isaPkg::dstIRd;
         end
         isaPkg::opJ: begin
            immSrc = 1'b1;
         end
         isaPkg::opJal: begin
            immSrc = 1'b1;
            regSrc = isaPkg::srcPc;
            regDst = isaPkg::dstR7;
         end
         isaPkg::opJr: begin
            aluJump = 1'b1;
            bSrc    = isaPkg::bExt8;
         end
         isaPkg::opJalr: begin
            aluJump = 1'b1;
            bSrc    = isaPkg::bExt8;
            regSrc  = isaPkg::srcPc;
            regDst  = isaPkg::dstR7;
         end
         isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
            brType = {1'b1, opcode[1:0]};
         end
         isaPkg::opHalt, isaPkg::opNop: begin
            regWrt = 1'b0;
         end
         default: begin
            regWrt = 1'b0;
         end
      endcase
   end

   // Carry-in completes the two's complement of an inverted operand
   assign cin = invA | invB;

   ///////////////////////////////////////////////////////////////////////
   // Immediates and B operand
   ///////////////////////////////////////////////////////////////////////

   assign ext5 = zeroExt ? {11'h000, instruction.i.imm5}
                         : {{11{instruction.i.imm5[4]}}, instruction.i.imm5};
   assign ext8 = zeroExt ? {8'h00, instruction.b.imm8}
                         : {{8{instruction.b.imm8[7]}}, instruction.b.imm8};

   // Old rs moves up a byte and the zero-extended byte fills in below
   assign slbiVal = (opA << 8) | ext8;

   always_comb begin
      case (bSrc)
         isaPkg::bRt:   opB = rtData;
         isaPkg::bExt5: opB = ext5;
         isaPkg::bExt8: opB = ext8;
         default:       opB = slbiVal;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // Writeback select
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (regDst)
         isaPkg::dstIRd: wrSel = instruction.i.rd;
         isaPkg::dstRRd: wrSel = instruction.r.rd;
         isaPkg::dstRs:  wrSel = instruction.r.rs;
         default:        wrSel = 3'd7;
      endcase
   end

   // Only a valid instruction may write
   assign wrEn = regWrt & instrValid;

   regFile u_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdSel1  (instruction.r.rs),
      .rdSel2  (instruction.r.rt),
      .wrSel   (wrSel),
      .wrData  (wrData),
      .wrEn    (wrEn),
      .rdData1 (opA),
      .rdData2 (rtData),
      .err     (err)
   );

endmodule
`default_nettype wire

/* verilog/execCore.sv */
/*
   Single-cycle decode and execute datapath
*/
`default_nettype none
`timescale 1ns/100ps
module execCore (
   input  wire                    clk,
   input  wire                    rstN,
   input  wire isaPkg::instrWord  instruction,
   input  wire                    instrValid,
   output logic [15:0]            result,
   output logic [2:0]             wrReg,
   output logic                   wrEn,
   output logic                   memWrt,
   output logic                   immSrc,
   output logic                   aluJump,
   output isaPkg::brTypeT         brType,
   output logic                   err
);

   // Decode to execute
   logic [15:0]      opA;
   logic [15:0]      opB;
   isaPkg::aluOp     oper;
   logic             invA;
   logic             invB;
   logic             cin;
   isaPkg::regSrcSel regSrc;

   // Result loops back as write data in the same cycle
   decode u_decode (
      .clk         (clk),
      .rstN        (rstN),
      .instruction (instruction),
      .instrValid  (instrValid),
      .wrData      (result),
      .opA         (opA),
      .opB         (opB),
      // Store data has no memory stage to go to here
      .rtData      (),
      .oper        (oper),
      .invA        (invA),
      .invB        (invB),
      .cin         (cin),
      .regSrc      (regSrc),
      .wrSel       (wrReg),
      .wrEn        (wrEn),
      .immSrc      (immSrc),
      .aluJump     (aluJump),
      .memWrt      (memWrt),
      .brType      (brType),
      .err         (err)
   );

   execute u_execute (
      .opA         (opA),
      .opB         (opB),
      .oper        (oper),
      .invA        (invA),
      .invB        (invB),
      .cin         (cin),
      .regSrc      (regSrc),
      .instruction (instruction),
      .result      (result)
   );

endmodule
`default_nettype wire

/* verilog/execute.sv */
/*
   Execute stage with adder, logic unit and shifter
   Compare flags, bit reverse and writeback source select
*/
`default_nettype none
`timescale 1ns/100ps
module execute (
   input  wire  [15:0]            opA,
   input  wire  [15:0]            opB,
   input  wire isaPkg::aluOp      oper,
   input  wire                    invA,
   input  wire                    invB,
   input  wire                    cin,
   input  wire isaPkg::regSrcSel  regSrc,
   input  wire isaPkg::instrWord  instruction,
   output logic [15:0]            result
);

   logic [15:0] aIn;
   logic [15:0] bIn;
   logic [16:0] sum;
   logic [3:0]  amt;
   logic [31:0] rolFull;
   logic [31:0] rorFull;
   logic [15:0] aluOut;
   logic [15:0] btrOut;
   logic [15:0] stageOut;
   logic        ovf;
   logic        isZero;
   logic        isLess;

   ///////////////////////////////////////////////////////////////////////
   // Adder and logic unit
   ///////////////////////////////////////////////////////////////////////

   assign aIn = invA ? ~opA : opA;
   assign bIn = invB ? ~opB : opB;

   // Bit 16 is the carry out used by SCO
   assign sum = {1'b0, aIn} + {1'b0, bIn} + {16'h0000, cin};

   // Shift amount is the low four bits of B
   assign amt = opB[3:0];

   // Doubled word turns a rotate into a plain shift
   assign rolFull = {opA, opA} << amt;
   assign rorFull = {opA, opA} >> amt;

   always_comb begin
      case (oper)
         isaPkg::aluRol: aluOut = rolFull[31:16];
         isaPkg::aluSll: aluOut = opA << amt;
         isaPkg::aluRor: aluOut = rorFull[15:0];
         isaPkg::aluSrl: aluOut = opA >> amt;
         isaPkg::aluAdd: aluOut = sum[15:0];
         isaPkg::aluAnd: aluOut = aIn & bIn;
         isaPkg::aluOr:  aluOut = aIn | bIn;
         default:        aluOut = aIn ^ bIn;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // Compare flags
   ///////////////////////////////////////////////////////////////////////

   // Signed overflow when both inputs agree in sign and the sum does not
   assign ovf    = (aIn[15] == bIn[15]) && (sum[15] != aIn[15]);
   assign isZero = (sum[15:0] == 16'h0000);
   // rs below rt once overflow is folded into the sign
   assign isLess = sum[15] ^ ovf;

   // Bit reverse of rs for BTR
   always_comb begin
      for (int i = 0; i < 16; i++) begin
         btrOut[i] = opA[15 - i];
      end
   end

   // Compares and BTR override the ALU word
   always_comb begin
      case (instruction.r.opcode)
         isaPkg::opSeq: stageOut = {15'h0000, isZero};
         isaPkg::opSlt: stageOut = {15'h0000, isLess};
         isaPkg::opSle: stageOut = {15'h0000, isLess | isZero};
         isaPkg::opSco: stageOut = {15'h0000, sum[16]};
         isaPkg::opBtr: stageOut = btrOut;
         default:       stageOut = aluOut;
      endcase
   end

   // LBI and SLBI write the B operand as is
   assign result = (regSrc == isaPkg::srcB) ? opB : stageOut;

endmodule
`default_nettype wire

/* verilog/isaPkg.sv */
/*
   Instruction formats, opcodes and control encodings for the 16-bit ISA
   Shared by decode, execute and the top level
*/
`default_nettype none
package isaPkg;

   ///////////////////////////////////////////////////////////////////////
   // Instruction word views
   ///////////////////////////////////////////////////////////////////////

   // Register format
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] funct;
   } rFmt;

   // Immediate format with 5-bit immediate
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm5;
   } iFmt;

   // Byte immediate format used by LBI, SLBI, branches and JR
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [7:0] imm8;
   } bFmt;

   // Jump displacement format
   typedef struct packed {
      logic [4:0]  opcode;
      logic [10:0] disp;
   } jFmt;

   // Opcode sits in the top five bits of every view
   typedef union packed {
      rFmt r;
      iFmt i;
      bFmt b;
      jFmt j;
   } instrWord;

   ///////////////////////////////////////////////////////////////////////
   // Opcodes
   ///////////////////////////////////////////////////////////////////////

   localparam logic [4:0] opHalt  = 5'b00000;
   localparam logic [4:0] opNop   = 5'b00001;
   localparam logic [4:0] opJ     = 5'b00100;
   localparam logic [4:0] opJr    = 5'b00101;
   localparam logic [4:0] opJal   = 5'b00110;
   localparam logic [4:0] opJalr  = 5'b00111;
   localparam logic [4:0] opAddi  = 5'b01000;
   localparam logic [4:0] opSubi  = 5'b01001;
   localparam logic [4:0] opXori  = 5'b01010;
   localparam logic [4:0] opAndni = 5'b01011;
   localparam logic [4:0] opBeqz  = 5'b01100;
   localparam logic [4:0] opBnez  = 5'b01101;
   localparam logic [4:0] opBltz  = 5'b01110;
   localparam logic [4:0] opBgez  = 5'b01111;
   localparam logic [4:0] opSt    = 5'b10000;
   localparam logic [4:0] opLd    = 5'b10001;
   localparam logic [4:0] opSlbi  = 5'b10010;
   localparam logic [4:0] opRoli  = 5'b10100;
   localparam logic [4:0] opSlli  = 5'b10101;
   localparam logic [4:0] opRori  = 5'b10110;
   localparam logic [4:0] opSrli  = 5'b10111;
   localparam logic [4:0] opLbi   = 5'b11000;
   localparam logic [4:0] opBtr   = 5'b11001;
   localparam logic [4:0] opShift = 5'b11010;
   localparam logic [4:0] opAlu   = 5'b11011;
   localparam logic [4:0] opSeq   = 5'b11100;
   localparam logic [4:0] opSlt   = 5'b11101;
   localparam logic [4:0] opSle   = 5'b11110;
   localparam logic [4:0] opSco   = 5'b11111;

   ///////////////////////////////////////////////////////////////////////
   // Control encodings
   ///////////////////////////////////////////////////////////////////////

   // Shift group is 0xx so the low bits copy straight from opcode or funct
   typedef logic [2:0] aluOp;
   localparam aluOp aluRol = 3'b000;
   localparam aluOp aluSll = 3'b001;
   localparam aluOp aluRor = 3'b010;
   localparam aluOp aluSrl = 3'b011;
   localparam aluOp aluAdd = 3'b100;
   localparam aluOp aluAnd = 3'b101;
   localparam aluOp aluOr  = 3'b110;
   localparam aluOp aluXor = 3'b111;

   // B operand source
   typedef logic [1:0] bSrcSel;
   localparam bSrcSel bRt   = 2'b00;
   localparam bSrcSel bExt5 = 2'b01;
   localparam bSrcSel bExt8 = 2'b10;
   localparam bSrcSel bSlbi = 2'b11;

   // Writeback source
   typedef logic [1:0] regSrcSel;
   localparam regSrcSel srcPc  = 2'b00;
   localparam regSrcSel srcMem = 2'b01;
   localparam regSrcSel srcAlu = 2'b10;
   localparam regSrcSel srcB   = 2'b11;

   // Destination register select
   typedef logic [1:0] regDstSel;
   localparam regDstSel dstIRd = 2'b00;
   localparam regDstSel dstRRd = 2'b01;
   localparam regDstSel dstRs  = 2'b10;
   localparam regDstSel dstR7  = 2'b11;

   // Branch kind, top bit marks a branch
   typedef logic [2:0] brTypeT;
   localparam brTypeT brNone = 3'b000;

endpackage
`default_nettype wire

/* verilog/regFile.sv */
/*
   Eight-entry 16-bit register file
   Two combinational reads, one write on the rising edge
*/
`default_nettype none
`timescale 1ns/100ps
module regFile (
   input  wire         clk,
   input  wire         rstN,
   input  wire  [2:0]  rdSel1,
   input  wire  [2:0]  rdSel2,
   input  wire  [2:0]  wrSel,
   input  wire  [15:0] wrData,
   input  wire         wrEn,
   output logic [15:0] rdData1,
   output logic [15:0] rdData2,
   output logic        err
);

   // Register storage
   logic [15:0] regs [0:7];

   ///////////////////////////////////////////////////////////////////////
   // Write port
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstN) begin
         // Every register reads zero after reset
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Read ports
   ///////////////////////////////////////////////////////////////////////

   // No bypass
   // A write shows up on the read ports in the next cycle
   assign rdData1 = regs[rdSel1];
   assign rdData2 = regs[rdSel2];

   // Unknown enable, or unknown select while writing
   assign err = (wrEn === 1'bx) || ((wrEn === 1'b1) && (^wrSel === 1'bx));

endmodule
`default_nettype wire
